// File: src/axi_read_master.sv
`timescale 1ns/10ps
`default_nettype none

module axi_read_master (
  input  wire                             clk,
  input  wire                             rst_n,

  input  wire                             req_valid,
  input  wire dma_pkg::dma_req_t          req,
  output logic                            req_ready,
  output logic [dma_pkg::AXI_DWIDTH-1:0]  data,
  output logic                            data_valid,
  input  wire                             data_ready,

  output dma_pkg::axi_ax_t                ar,
  output logic                            arvalid,
  input  wire                             arready,
  input  wire dma_pkg::axi_r_t            r,
  input  wire                             rvalid,
  output logic                            rready
);

  logic busy;
  logic req_fire;
  logic r_last_fire;

  assign req_fire    = req_valid & req_ready;
  assign r_last_fire = rvalid & rready & r.last;
  assign req_ready   = ~busy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      arvalid <= 1'b0;
    end else begin
      if (req_fire) begin
        busy <= 1'b1;
      end else if (r_last_fire) begin
        busy <= 1'b0;
      end
      if (req_fire) begin
        arvalid <= 1'b1;
      end else if (arready) begin
        arvalid <= 1'b0;
      end
    end
  end

  // AR payload, only 8 bits of length reach the bus
  always_ff @(posedge clk) begin
    if (req_fire) begin
      ar.addr  <= req.addr;
      ar.len   <= req.len[7:0];
      ar.size  <= req.size;
      ar.burst <= req.burst;
    end
  end

  // R beats go straight through to the stream
  assign data       = r.data;
  assign data_valid = rvalid;
  assign rready     = data_ready;

endmodule

`default_nettype wire

// File: src/axi_write_master.sv
`timescale 1ns/10ps
`default_nettype none

module axi_write_master (
  input  wire                             clk,
  input  wire                             rst_n,

  input  wire                             req_valid,
  input  wire dma_pkg::dma_req_t          req,
  output logic                            req_ready,
  input  wire  [dma_pkg::AXI_DWIDTH-1:0]  data,
  input  wire                             data_valid,
  output logic                            data_ready,

  output dma_pkg::axi_ax_t                aw,
  output logic                            awvalid,
  input  wire                             awready,
  output dma_pkg::axi_w_t                 w,
  output logic                            wvalid,
  input  wire                             wready,
  input  wire  [1:0]                      b_resp,
  input  wire                             bvalid,
  output logic                            bready
);

  logic       busy;
  logic       w_done;
  logic [7:0] beat_cnt;
  logic       req_fire;
  logic       w_fire;
  logic       b_fire;
  logic       w_open;

  assign req_fire = req_valid & req_ready;
  assign w_fire   = wvalid & wready;
  assign b_fire   = bvalid & bready;
  // busy until B, so one burst in flight at most
  assign req_ready = ~busy;
  assign w_open    = busy & ~w_done;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      awvalid <= 1'b0;
    end else begin
      if (req_fire) begin
        busy <= 1'b1;
      end else if (b_fire) begin
        busy <= 1'b0;
      end
      if (req_fire) begin
        awvalid <= 1'b1;
      end else if (awready) begin
        awvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_cnt <= '0;
      w_done   <= 1'b0;
    end else if (req_fire) begin
      beat_cnt <= '0;
      w_done   <= 1'b0;
    end else if (w_fire) begin
      beat_cnt <= beat_cnt + 8'd1;
      if (w.last) begin
        w_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      aw.addr  <= req.addr;
      aw.len   <= req.len[7:0];
      aw.size  <= req.size;
      aw.burst <= req.burst;
    end
  end

  // W beats pass from the stream only inside an accepted burst
  assign w.data     = data;
  assign w.strb     = '1;
  assign w.last     = beat_cnt == aw.len;
  assign wvalid     = data_valid & w_open;
  assign data_ready = wready & w_open;

  // response code is taken and dropped
  assign bready = w_done;

endmodule

`default_nettype wire

// File: src/dma_controller.sv
`timescale 1ns/10ps
`default_nettype none

module dma_controller (
  input  wire                                  clk,
  input  wire                                  rst_n,

  input  wire                                  start,
  input  wire dma_pkg::dma_cmd_t               cmd,
  output logic                                 done,
  output logic                                 idle,

  output logic                                 rd_req_valid,
  output dma_pkg::dma_req_t                    rd_req,
  input  wire                                  rd_req_ready,
  input  wire [dma_pkg::AXI_DWIDTH-1:0]        rd_data,
  input  wire                                  rd_data_valid,
  output logic                                 rd_data_ready,

  output logic                                 wr_req_valid,
  output dma_pkg::dma_req_t                    wr_req,
  input  wire                                  wr_req_ready,
  output logic [dma_pkg::AXI_DWIDTH-1:0]       wr_data,
  output logic                                 wr_data_valid,
  input  wire                                  wr_data_ready,

  output logic [dma_pkg::DMEM_AWIDTH-1:0]      dmem_addr,
  output logic [dma_pkg::DMEM_DWIDTH-1:0]      dmem_din,
  output logic [dma_pkg::DMEM_SWIDTH-1:0]      dmem_wbe,
  output logic                                 dmem_en,
  input  wire  [dma_pkg::DMEM_DWIDTH-1:0]      dmem_dout
);

  import dma_pkg::*;

  dma_state_e  state;
  dma_state_e  state_next;
  logic [31:0] rd_cnt;
  logic [31:0] wr_cnt;
  logic        done_q;
  logic        rd_req_fire;
  logic        wr_req_fire;
  logic        rd_data_fire;
  logic        wr_data_fire;
  logic        start_job;
  logic [31:0] rd_word;
  logic [31:0] wr_word;

  assign rd_req_fire  = rd_req_valid & rd_req_ready;
  assign wr_req_fire  = wr_req_valid & wr_req_ready;
  assign rd_data_fire = rd_data_valid & rd_data_ready;
  assign wr_data_fire = wr_data_valid & wr_data_ready;
  assign start_job    = (state == ST_IDLE) & start;

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (start) begin
          state_next = cmd.dir ? ST_WRITE_DDR : ST_READ_DDR;
        end
      end
      ST_READ_DDR: begin
        if (rd_cnt == cmd.len) begin
          state_next = ST_DONE;
        end
      end
      // first DMem read goes out here, data shows up next cycle
      ST_WRITE_DDR: state_next = ST_WRITE_DDR_DELAY;
      ST_WRITE_DDR_DELAY: begin
        // wr_cnt runs one ahead of the accepted beats
        if (wr_data_fire && (wr_cnt == cmd.len)) begin
          state_next = ST_DONE;
        end
      end
      ST_DONE: state_next = ST_IDLE;
      default: state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_cnt <= '0;
      wr_cnt <= '0;
    end else if (state == ST_IDLE) begin
      rd_cnt <= '0;
      wr_cnt <= '0;
    end else begin
      if (rd_data_fire) begin
        rd_cnt <= rd_cnt + 32'd1;
      end
      if ((state == ST_WRITE_DDR) || wr_data_fire) begin
        wr_cnt <= wr_cnt + 32'd1;
      end
    end
  end

  // request valids stay up until the master takes them
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_req_valid <= 1'b0;
      wr_req_valid <= 1'b0;
    end else begin
      if (start_job && !cmd.dir) begin
        rd_req_valid <= 1'b1;
      end else if (rd_req_fire) begin
        rd_req_valid <= 1'b0;
      end
      if (start_job && cmd.dir) begin
        wr_req_valid <= 1'b1;
      end else if (wr_req_fire) begin
        wr_req_valid <= 1'b0;
      end
    end
  end

  // sticky done, cleared by the next start
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_q <= 1'b0;
    end else if (start_job) begin
      done_q <= 1'b0;
    end else if (state == ST_DONE) begin
      done_q <= 1'b1;
    end
  end

  assign idle = state == ST_IDLE;
  assign done = done_q & ~start;

  assign rd_req.addr  = cmd.src_addr;
  assign rd_req.len   = cmd.len - 32'd1;
  assign rd_req.size  = AXI_SIZE_WORD;
  assign rd_req.burst = INCR;
  assign rd_data_ready = state == ST_READ_DDR;

  assign wr_req.addr  = cmd.dst_addr;
  assign wr_req.len   = cmd.len - 32'd1;
  assign wr_req.size  = AXI_SIZE_WORD;
  assign wr_req.burst = INCR;
  assign wr_data_valid = state == ST_WRITE_DDR_DELAY;
  assign wr_data       = dmem_dout;

  assign rd_word   = cmd.dst_addr + rd_cnt;
  assign wr_word   = cmd.src_addr + wr_cnt;
  assign dmem_addr = (state == ST_READ_DDR) ? rd_word[DMEM_AWIDTH-1:0] :
                                              wr_word[DMEM_AWIDTH-1:0];
  assign dmem_din  = rd_data;
  assign dmem_wbe  = {DMEM_SWIDTH{rd_data_fire}};
  // low under back-pressure so dmem_dout holds
  assign dmem_en   = (state == ST_WRITE_DDR) | wr_data_fire | rd_data_fire;

endmodule

`default_nettype wire

// File: src/dma_pkg.sv
`default_nettype none

package dma_pkg;

  // bus and memory widths
  localparam int AXI_AWIDTH  = 32;
  localparam int AXI_DWIDTH  = 32;
  localparam int AXI_SWIDTH  = AXI_DWIDTH / 8;
  localparam int DMEM_AWIDTH = 14;
  localparam int DMEM_DWIDTH = 32;
  localparam int DMEM_SWIDTH = DMEM_DWIDTH / 8;
  localparam int DMEM_DEPTH  = 1 << DMEM_AWIDTH;

  // 2^2 bytes per beat
  localparam logic [2:0] AXI_SIZE_WORD = 3'd2;

  typedef enum logic [1:0] {
    FIXED = 2'd0,
    INCR  = 2'd1,
    WRAP  = 2'd2
  } axi_burst_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_READ_DDR,
    ST_WRITE_DDR,
    ST_WRITE_DDR_DELAY,
    ST_DONE
  } dma_state_e;

  // dir 0: DDR -> DMem, dir 1: DMem -> DDR
  typedef struct packed {
    logic        dir;
    logic [31:0] src_addr;
    logic [31:0] dst_addr;
    logic [31:0] len;
  } dma_cmd_t;

  // len is beats minus one
  typedef struct packed {
    logic [AXI_AWIDTH-1:0] addr;
    logic [31:0]           len;
    logic [2:0]            size;
    axi_burst_e            burst;
  } dma_req_t;

  typedef struct packed {
    logic [AXI_AWIDTH-1:0] addr;
    logic [7:0]            len;
    logic [2:0]            size;
    axi_burst_e            burst;
  } axi_ax_t;

  typedef struct packed {
    logic [AXI_DWIDTH-1:0] data;
    logic [AXI_SWIDTH-1:0] strb;
    logic                  last;
  } axi_w_t;

  typedef struct packed {
    logic [AXI_DWIDTH-1:0] data;
    logic [1:0]            resp;
    logic                  last;
  } axi_r_t;

endpackage

`default_nettype wire

// File: src/dma_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

module dma_subsystem (
  input  wire                      clk,
  input  wire                      rst_n,

  input  wire                      dma_start,
  input  wire dma_pkg::dma_cmd_t   dma_cmd,
  output logic                     dma_done,
  output logic                     dma_idle,

  output dma_pkg::axi_ax_t         ar,
  output logic                     arvalid,
  input  wire                      arready,
  input  wire dma_pkg::axi_r_t     r,
  input  wire                      rvalid,
  output logic                     rready,

  output dma_pkg::axi_ax_t         aw,
  output logic                     awvalid,
  input  wire                      awready,
  output dma_pkg::axi_w_t          w,
  output logic                     wvalid,
  input  wire                      wready,
  input  wire  [1:0]               b_resp,
  input  wire                      bvalid,
  output logic                     bready
);

  import dma_pkg::*;

  logic                   rd_req_valid;
  dma_req_t               rd_req;
  logic                   rd_req_ready;
  logic [AXI_DWIDTH-1:0]  rd_data;
  logic                   rd_data_valid;
  logic                   rd_data_ready;

  logic                   wr_req_valid;
  dma_req_t               wr_req;
  logic                   wr_req_ready;
  logic [AXI_DWIDTH-1:0]  wr_data;
  logic                   wr_data_valid;
  logic                   wr_data_ready;

  logic [DMEM_AWIDTH-1:0] dmem_addr;
  logic [DMEM_DWIDTH-1:0] dmem_din;
  logic [DMEM_DWIDTH-1:0] dmem_dout;
  logic [DMEM_SWIDTH-1:0] dmem_wbe;
  logic                   dmem_en;

  dma_controller ctrl_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .start         (dma_start),
    .cmd           (dma_cmd),
    .done          (dma_done),
    .idle          (dma_idle),
    .rd_req_valid  (rd_req_valid),
    .rd_req        (rd_req),
    .rd_req_ready  (rd_req_ready),
    .rd_data       (rd_data),
    .rd_data_valid (rd_data_valid),
    .rd_data_ready (rd_data_ready),
    .wr_req_valid  (wr_req_valid),
    .wr_req        (wr_req),
    .wr_req_ready  (wr_req_ready),
    .wr_data       (wr_data),
    .wr_data_valid (wr_data_valid),
    .wr_data_ready (wr_data_ready),
    .dmem_addr     (dmem_addr),
    .dmem_din      (dmem_din),
    .dmem_wbe      (dmem_wbe),
    .dmem_en       (dmem_en),
    .dmem_dout     (dmem_dout)
  );

  axi_read_master rd_master_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (rd_req_valid),
    .req        (rd_req),
    .req_ready  (rd_req_ready),
    .data       (rd_data),
    .data_valid (rd_data_valid),
    .data_ready (rd_data_ready),
    .ar         (ar),
    .arvalid    (arvalid),
    .arready    (arready),
    .r          (r),
    .rvalid     (rvalid),
    .rready     (rready)
  );

  axi_write_master wr_master_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (wr_req_valid),
    .req        (wr_req),
    .req_ready  (wr_req_ready),
    .data       (wr_data),
    .data_valid (wr_data_valid),
    .data_ready (wr_data_ready),
    .aw         (aw),
    .awvalid    (awvalid),
    .awready    (awready),
    .w          (w),
    .wvalid     (wvalid),
    .wready     (wready),
    .b_resp     (b_resp),
    .bvalid     (bvalid),
    .bready     (bready)
  );

  dmem dmem_i (
    .clk  (clk),
    .en   (dmem_en),
    .addr (dmem_addr),
    .din  (dmem_din),
    .wbe  (dmem_wbe),
    .dout (dmem_dout)
  );

endmodule

`default_nettype wire

// File: src/dmem.sv
`timescale 1ns/10ps
`default_nettype none

module dmem (
  input  wire                               clk,
  input  wire                               en,
  input  wire  [dma_pkg::DMEM_AWIDTH-1:0]   addr,
  input  wire  [dma_pkg::DMEM_DWIDTH-1:0]   din,
  input  wire  [dma_pkg::DMEM_SWIDTH-1:0]   wbe,
  output logic [dma_pkg::DMEM_DWIDTH-1:0]   dout
);

  import dma_pkg::*;

  logic [DMEM_DWIDTH-1:0] mem [0:DMEM_DEPTH-1];

  // read returns the old word on a write cycle
  always_ff @(posedge clk) begin
    if (en) begin
      for (int i = 0; i < DMEM_SWIDTH; i++) begin
        if (wbe[i]) begin
          mem[addr][i*8 +: 8] <= din[i*8 +: 8];
        end
      end
      dout <= mem[addr];
    end
  end

endmodule

`default_nettype wire

// File: tb.f
src/dma_pkg.sv
src/dma_controller.sv
src/axi_read_master.sv
src/axi_write_master.sv
src/dmem.sv
src/dma_subsystem.sv
test/dma_sva.sv
test/tb_dma.sv

// File: test/dma_sva.sv
`timescale 1ns/10ps
`default_nettype none

module dma_sva (
  input wire                                 clk,
  input wire                                 rst_n,
  input wire                                 rd_req_valid,
  input wire                                 rd_req_ready,
  input wire                                 wr_req_valid,
  input wire                                 wr_req_ready,
  input wire                                 rd_data_valid,
  input wire                                 rd_data_ready,
  input wire [31:0]                          rd_cnt,
  input wire dma_pkg::dma_cmd_t              cmd,
  input wire [dma_pkg::DMEM_SWIDTH-1:0]      dmem_wbe,
  input wire                                 done,
  input wire                                 idle
);

  int assert_errors = 0;

  rd_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rd_req_valid && !rd_req_ready |=> rd_req_valid)
    else begin
      $error("rd_req_valid dropped before rd_req_ready");
      assert_errors++;
    end

  wr_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    wr_req_valid && !wr_req_ready |=> wr_req_valid)
    else begin
      $error("wr_req_valid dropped before wr_req_ready");
      assert_errors++;
    end

  // DMem writes only on an accepted beat inside the job length
  wbe_on_beat: assert property (@(posedge clk) disable iff (!rst_n)
    (|dmem_wbe) |-> (rd_data_valid && rd_data_ready && (rd_cnt < cmd.len)))
    else begin
      $error("dmem_wbe set outside an expected read beat");
      assert_errors++;
    end

  done_idle: assert property (@(posedge clk) disable iff (!rst_n) done |-> idle)
    else begin
      $error("done high while controller busy");
      assert_errors++;
    end

endmodule

bind dma_controller dma_sva sva_i (.*);

`default_nettype wire

// File: test/tb_dma.sv
`timescale 1ns/10ps
`default_nettype none

module tb_dma;

  import dma_pkg::*;

  localparam int DDR_WORDS   = 4096;
  localparam int JOB_TIMEOUT = 20000;

  logic clk;
  logic rst_n;
  logic dma_start;
  dma_cmd_t dma_cmd;
  logic dma_done;
  logic dma_idle;
  axi_ax_t ar;
  logic arvalid;
  logic arready;
  axi_r_t r;
  logic rvalid;
  logic rready;
  axi_ax_t aw;
  logic awvalid;
  logic awready;
  axi_w_t w;
  logic wvalid;
  logic wready;
  logic [1:0] b_resp;
  logic bvalid;
  logic bready;

  logic [31:0] ddr_mem [0:DDR_WORDS-1];
  logic [31:0] model_ddr [0:DDR_WORDS-1];
  logic [31:0] model_dmem [0:DMEM_DEPTH-1];
  logic [31:0] w_buf [$];
  logic [31:0] lcg_state = 32'd18772;
  dma_cmd_t cur_cmd;
  int unsigned rd_word = 0;
  int unsigned rd_left = 0;
  int unsigned rd_wait = 0;
  logic aw_seen = 1'b0;
  logic b_pending = 1'b0;
  int unsigned aw_word = 0;
  int unsigned b_wait = 0;
  int unsigned b_count = 0;
  int unsigned writes_issued = 0;
  int unsigned compares_done = 0;
  event compare_req;

  dma_subsystem dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int unsigned rand_below(input int unsigned n);
    logic [31:0] v;
    v = lcg_next();
    return {16'd0, v[31:16]} % n;
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped");
  endtask

  task automatic compare_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
    if (got !== exp) begin
      $display("ERROR at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      stop_with_failure("value mismatch");
    end
  endtask

  task automatic verify_burst(input axi_ax_t ax, input logic [31:0] addr, input string ch);
    compare_value(ax.addr, addr, {ch, " address"});
    compare_value(32'(ax.len), cur_cmd.len - 32'd1, {ch, " length"});
    compare_value(32'(ax.size), 32'd2, {ch, " size"});
    compare_value(32'(ax.burst), 32'(INCR), {ch, " burst type"});
  endtask

  // DDR addresses are bytes and DMem addresses are words
  function automatic void apply_copy(input dma_cmd_t c);
    for (int i = 0; i < c.len; i++) begin
      if (c.dir) begin
        model_ddr[c.dst_addr / 4 + i] = model_dmem[(c.src_addr + i) % DMEM_DEPTH];
      end else begin
        model_dmem[(c.dst_addr + i) % DMEM_DEPTH] = model_ddr[c.src_addr / 4 + i];
      end
    end
  endfunction

  // DDR slave
  always @(posedge clk) begin
    if (rst_n) begin
      // read channels
      arready <= (rand_below(4) != 0);
      if (arvalid && arready) begin
        verify_burst(ar, cur_cmd.src_addr, "AR");
        rd_word = ar.addr >> 2;
        rd_left = ar.len + 1;
        rd_wait = rand_below(3);
      end
      if (rvalid && rready) begin
        rd_word++;
        rd_left--;
        rd_wait = rand_below(3);
      end
      if (!rvalid || rready) begin
        if (rd_left != 0 && rd_wait == 0) begin
          rvalid <= 1'b1;
          r      <= {ddr_mem[rd_word], 2'b00, rd_left == 1};
        end else begin
          rvalid <= 1'b0;
          if (rd_wait != 0) rd_wait--;
        end
      end
      // W may arrive before AW
      awready <= (rand_below(4) != 0);
      wready  <= (rand_below(4) != 0);
      if (awvalid && awready) begin
        verify_burst(aw, cur_cmd.dst_addr, "AW");
        aw_seen = 1'b1;
        aw_word = aw.addr >> 2;
      end
      if (wvalid && wready) begin
        compare_value(32'(w.strb), 32'hf, "wstrb");
        compare_value(32'(w.last), 32'(w_buf.size() == cur_cmd.len - 1), "wlast");
        w_buf.push_back(w.data);
      end
      if (aw_seen && w_buf.size() == cur_cmd.len) begin
        foreach (w_buf[i]) ddr_mem[aw_word + i] = w_buf[i];
        w_buf.delete();
        aw_seen   = 1'b0;
        b_pending = 1'b1;
        b_wait    = rand_below(4);
      end
      if (bvalid && bready) begin
        bvalid <= 1'b0;
        b_count++;
      end else if (b_pending) begin
        if (b_wait != 0) begin
          b_wait--;
        end else begin
          bvalid    <= 1'b1;
          b_pending = 1'b0;
        end
      end
    end
  end

  // compare process
  initial begin
    forever begin
      @(compare_req);
      for (int i = 0; i < DDR_WORDS; i++) begin
        compare_value(ddr_mem[i], model_ddr[i], $sformatf("DDR word %0d", i));
      end
      if (!cur_cmd.dir) begin
        for (int i = 0; i < cur_cmd.len; i++) begin
          compare_value(dut_i.dmem_i.mem[(cur_cmd.dst_addr + i) % DMEM_DEPTH],
                        model_dmem[(cur_cmd.dst_addr + i) % DMEM_DEPTH],
                        $sformatf("DMem word %0d", (cur_cmd.dst_addr + i) % DMEM_DEPTH));
        end
      end
      compares_done++;
    end
  end

  always @(dut_i.ctrl_i.sva_i.assert_errors) begin
    if (dut_i.ctrl_i.sva_i.assert_errors != 0) begin
      stop_with_failure("a controller assertion failed");
    end
  end

  task automatic run_copy(input logic dir, input logic [31:0] src, input logic [31:0] dst,
                          input logic [31:0] len);
    dma_cmd_t    c;
    int unsigned n;
    int unsigned seen;
    c.dir      = dir;
    c.src_addr = src;
    c.dst_addr = dst;
    c.len      = len;
    @(posedge clk);
    dma_cmd   <= c;
    cur_cmd   <= c;
    dma_start <= 1'b1;
    @(negedge clk);
    compare_value(32'(dma_done), 32'd0, "dma_done while dma_start high");
    @(posedge clk);
    dma_start <= 1'b0;
    n = 0;
    @(negedge clk);
    while (!dma_done && n < JOB_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!dma_done) stop_with_failure("timed out waiting for dma_done");
    if (dir) begin
      writes_issued++;
      n = 0;
      while (b_count != writes_issued && n < JOB_TIMEOUT) begin
        @(negedge clk);
        n++;
      end
      if (b_count != writes_issued) stop_with_failure("timed out waiting for the B response");
    end
    apply_copy(c);
    seen = compares_done;
    -> compare_req;
    n = 0;
    while (compares_done == seen && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (compares_done == seen) stop_with_failure("compare process never finished");
    // done is sticky until the next start
    repeat (rand_below(3) + 1) begin
      @(negedge clk);
      compare_value(32'(dma_done), 32'd1, "dma_done after job");
      compare_value(32'(dma_idle), 32'd1, "dma_idle after job");
    end
  endtask

  // DDR to DMem and back out to another DDR page
  task automatic round_trip(input int unsigned len);
    int unsigned src_page;
    int unsigned dst_page;
    int unsigned dmem_word;
    logic [31:0] src_byte;
    logic [31:0] dst_byte;
    src_page  = rand_below(4);
    dst_page  = (src_page + 1 + rand_below(3)) % 4;
    src_byte  = (src_page * 1024 + rand_below(1024 - len + 1)) * 4;
    dst_byte  = (dst_page * 1024 + rand_below(1024 - len + 1)) * 4;
    dmem_word = rand_below(DMEM_DEPTH - len + 1);
    run_copy(1'b0, src_byte, dmem_word, len);
    run_copy(1'b1, dmem_word, dst_byte, len);
  endtask

  initial begin
    rst_n     = 1'b0;
    dma_start = 1'b0;
    dma_cmd   = '0;
    cur_cmd   = '0;
    arready   = 1'b0;
    r         = '0;
    rvalid    = 1'b0;
    awready   = 1'b0;
    wready    = 1'b0;
    b_resp    = 2'b00;
    bvalid    = 1'b0;
    for (int i = 0; i < DDR_WORDS; i++) begin
      ddr_mem[i]   = i * 32'h9e3779b1 ^ 32'h5a5a0000;
      model_ddr[i] = ddr_mem[i];
    end
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    compare_value(32'(dma_idle), 32'd1, "dma_idle after reset");
    compare_value(32'(dma_done), 32'd0, "dma_done after reset");
    compare_value({arvalid, awvalid, wvalid, bready}, 32'd0, "AXI valids after reset");
    round_trip(1);
    round_trip(256);
    repeat (10) round_trip(rand_below(256) + 1);
    if (dut_i.ctrl_i.sva_i.assert_errors == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      stop_with_failure("controller assertions failed during the run");
    end
  end

endmodule

`default_nettype wire
